// ==== l1d_pkg.sv ====
// L1 data cache package with geometry, vector types and controller states
package l1d_pkg;

  // ==================================================
  // Vector types
  // ==================================================
  typedef logic [31:0]  addr_t;       // Byte address
  typedef logic [31:0]  word_t;
  typedef logic [21:0]  tag_t;        // addr[31:10]
  typedef logic [5:0]   index_t;      // addr[9:4]
  typedef logic [3:0]   offset_t;     // addr[3:0]
  typedef logic [127:0] line_t;
  typedef logic [15:0]  line_mask_t;  // One bit per byte, high writes
  typedef logic [2:0]   acc_type_t;

  // ==================================================
  // Geometry
  // ==================================================
  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES  = 64;

  // Access type codes, shared by core and memory ports
  localparam acc_type_t TYPE_BYTE    = 3'd0;
  localparam acc_type_t TYPE_HWORD   = 3'd1;
  localparam acc_type_t TYPE_WORD    = 3'd2;
  localparam acc_type_t TYPE_BYTE_U  = 3'd4;
  localparam acc_type_t TYPE_HWORD_U = 3'd5;

  // ==================================================
  // Controller states
  // ==================================================
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    FILL_WRITE,   // Commit refilled line with tag and valid
    STORE,        // Write-through beat
    DONE
  } l1d_state_t;

endpackage

// ==== l1d_store_merge.sv ====
`timescale 1ns/10ps
// Store merge unit building the byte mask and lane-aligned line data of a store
module l1d_store_merge (
  input  l1d_pkg::offset_t    offset,
  input  logic [1:0]          addr_low,
  input  l1d_pkg::acc_type_t  acc_type,
  input  l1d_pkg::word_t      wdata,
  output l1d_pkg::line_mask_t mask,
  output l1d_pkg::line_t      line
);
  import l1d_pkg::*;

  logic [3:0] word_mask;
  word_t      word_data;

  // Byte enables and replicated data within one word
  always_comb
  begin
    word_mask = 4'b0000;
    word_data = '0;
    case (acc_type)
      TYPE_BYTE, TYPE_BYTE_U:
      begin
        word_mask = 4'b0001 << addr_low;
        word_data = {4{wdata[7:0]}};
      end
      TYPE_HWORD, TYPE_HWORD_U:
      begin
        word_mask = addr_low[1] ? 4'b1100 : 4'b0011;
        word_data = {2{wdata[15:0]}};
      end
      TYPE_WORD:
      begin
        word_mask = 4'b1111;
        word_data = wdata;
      end
      default:
      begin
        word_mask = 4'b0000;   // Unknown type writes nothing
      end
    endcase
  end

  // Place enables into the lane picked by offset[3:2]
  always_comb
  begin
    mask = '0;
    mask[4*offset[3:2] +: 4] = word_mask;
  end

  assign line = {LINE_WORDS{word_data}};  // Mask selects the live lane

endmodule

// ==== l1d_line_store.sv ====
`timescale 1ns/10ps
// Line store with tag array, per-line valid bits and byte-writable data array
module l1d_line_store (
  input  logic                clk,
  input  logic                rst,
  input  l1d_pkg::index_t     index,
  input  l1d_pkg::tag_t       tag_in,
  input  logic                read,
  input  logic                tag_write,
  input  l1d_pkg::line_mask_t mask,
  input  l1d_pkg::line_t      line_in,
  output l1d_pkg::tag_t       tag_out,
  output logic                valid,
  output l1d_pkg::line_t      line_out
);
  import l1d_pkg::*;

  tag_t                 tag_mem  [NUM_LINES];
  line_t                data_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid_bits;

  // ==================================================
  // Valid bits
  // ==================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_bits <= '0;
      valid      <= 1'b0;
    end
    else
    begin
      if (tag_write)
      begin
        valid_bits[index] <= 1'b1;   // Set together with the tag
      end
      if (read)
      begin
        valid <= valid_bits[index];
      end
    end
  end

  // ==================================================
  // Tag and data arrays
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (tag_write)
    begin
      tag_mem[index] <= tag_in;
    end
    for (int b = 0; b < $bits(line_mask_t); b++)
    begin
      if (mask[b])
      begin
        data_mem[index][8*b +: 8] <= line_in[8*b +: 8];
      end
    end
  end

  // Registered read, old contents on a same-cycle write
  always_ff @(posedge clk)
  begin
    if (read)
    begin
      tag_out  <= tag_mem[index];
      line_out <= data_mem[index];
    end
  end

endmodule

// ==== l1d_controller.sv ====
`timescale 1ns/10ps
// L1 data cache controller for lookup, line refill, write-through and response
module l1d_controller (
  input  logic                clk,
  input  logic                rst,
  // Core side
  input  l1d_pkg::addr_t      core_addr,
  input  logic                core_req,
  input  logic                core_write,
  input  l1d_pkg::word_t      core_in,
  input  l1d_pkg::acc_type_t  core_type,
  output l1d_pkg::word_t      core_out,
  output logic                core_wait,
  // Memory side
  input  l1d_pkg::word_t      D_out,
  input  logic                D_wait,
  output logic                D_req,
  output logic                D_write,
  output l1d_pkg::addr_t      D_addr,
  output l1d_pkg::word_t      D_in,
  output l1d_pkg::acc_type_t  D_type,
  // Line store
  output l1d_pkg::index_t     ls_index,
  output l1d_pkg::tag_t       ls_tag_in,
  output logic                ls_read,
  output logic                ls_tag_write,
  output l1d_pkg::line_mask_t ls_mask,
  output l1d_pkg::line_t      ls_line_in,
  input  l1d_pkg::tag_t       ls_tag_out,
  input  logic                ls_valid,
  input  l1d_pkg::line_t      ls_line_out,
  // Store merge
  input  l1d_pkg::line_mask_t sm_mask,
  input  l1d_pkg::line_t      sm_line
);
  import l1d_pkg::*;

  l1d_state_t state;
  l1d_state_t state_next;

  addr_t      req_addr;
  logic       req_write;
  word_t      req_in;
  acc_type_t  req_type;

  logic       hit;
  logic       hit_q;       // Lookup result kept for the store beat
  logic [1:0] beat;        // Refill word counter
  logic       beat_done;
  line_t      fill_line;
  word_t      result;

  assign hit       = ls_valid && (ls_tag_out == req_addr[31:10]);
  assign beat_done = D_req && !D_wait;

  // ==================================================
  // State and control registers
  // ==================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      beat  <= '0;
      hit_q <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (state == LOOKUP)
      begin
        hit_q <= hit;
        beat  <= '0;
      end
      else if (state == REFILL && beat_done)
      begin
        beat <= beat + 2'd1;
      end
    end
  end

  // Request capture, refill assembly and response word
  always_ff @(posedge clk)
  begin
    if (state == IDLE && core_req)
    begin
      req_addr  <= core_addr;
      req_write <= core_write;
      req_in    <= core_in;
      req_type  <= core_type;
    end
    if (state == LOOKUP)
    begin
      result <= ls_line_out[32*req_addr[3:2] +: 32];
    end
    if (state == REFILL && beat_done)
    begin
      fill_line[32*beat +: 32] <= D_out;
      if (beat == req_addr[3:2])
      begin
        result <= D_out;   // Requested word
      end
    end
  end

  // ==================================================
  // Next state
  // ==================================================
  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (core_req)
        begin
          state_next = LOOKUP;
        end
      end
      LOOKUP:
      begin
        if (req_write)
        begin
          state_next = STORE;   // Write-through on hit or miss
        end
        else if (hit)
        begin
          state_next = DONE;
        end
        else
        begin
          state_next = REFILL;
        end
      end
      REFILL:
      begin
        if (beat_done && beat == 2'(LINE_WORDS - 1))
        begin
          state_next = FILL_WRITE;
        end
      end
      FILL_WRITE: state_next = DONE;
      STORE:
      begin
        if (beat_done)
        begin
          state_next = DONE;
        end
      end
      DONE:       state_next = IDLE;  // Never take a held request twice
      default:    state_next = IDLE;
    endcase
  end

  // ==================================================
  // Outputs
  // ==================================================
  always_comb
  begin
    core_wait = 1'b1;
    if (state == IDLE)
    begin
      core_wait = core_req;
    end
    else if (state == DONE)
    begin
      core_wait = 1'b0;
    end
  end

  assign core_out = result;

  assign D_req   = (state == REFILL) || (state == STORE);
  assign D_write = (state == STORE);
  assign D_addr  = (state == STORE) ? req_addr : {req_addr[31:4], beat, 2'b00};
  assign D_in    = req_in;
  assign D_type  = (state == STORE) ? req_type : TYPE_WORD;

  assign ls_index     = (state == IDLE) ? core_addr[9:4] : req_addr[9:4];
  assign ls_tag_in    = req_addr[31:10];
  assign ls_read      = (state == IDLE) && core_req;
  assign ls_tag_write = (state == FILL_WRITE);

  always_comb
  begin
    ls_mask    = '0;
    ls_line_in = fill_line;
    if (state == FILL_WRITE)
    begin
      ls_mask = '1;
    end
    else if (state == STORE && beat_done && hit_q)
    begin
      ls_mask    = sm_mask;   // Store hit updates only its bytes
      ls_line_in = sm_line;
    end
  end

endmodule

// ==== l1d_cache.sv ====
`timescale 1ns/10ps
// Direct-mapped write-through L1 data cache between core and word-wide memory port
module l1d_cache (
  input  logic               clk,
  input  logic               rst,
  input  l1d_pkg::addr_t     core_addr,
  input  logic               core_req,
  input  logic               core_write,
  input  l1d_pkg::word_t     core_in,
  input  l1d_pkg::acc_type_t core_type,
  input  l1d_pkg::word_t     D_out,
  input  logic               D_wait,
  output l1d_pkg::word_t     core_out,
  output logic               core_wait,
  output logic               D_req,
  output logic               D_write,
  output l1d_pkg::addr_t     D_addr,
  output l1d_pkg::word_t     D_in,
  output l1d_pkg::acc_type_t D_type
);
  import l1d_pkg::*;

  // Controller to line store
  index_t     ls_index;
  tag_t       ls_tag_in;
  logic       ls_read;
  logic       ls_tag_write;
  line_mask_t ls_mask;
  line_t      ls_line_in;
  tag_t       ls_tag_out;
  logic       ls_valid;
  line_t      ls_line_out;

  // Store merge results
  line_mask_t sm_mask;
  line_t      sm_line;

  l1d_controller controller_inst (
    .clk          (clk),
    .rst          (rst),
    .core_addr    (core_addr),
    .core_req     (core_req),
    .core_write   (core_write),
    .core_in      (core_in),
    .core_type    (core_type),
    .core_out     (core_out),
    .core_wait    (core_wait),
    .D_out        (D_out),
    .D_wait       (D_wait),
    .D_req        (D_req),
    .D_write      (D_write),
    .D_addr       (D_addr),
    .D_in         (D_in),
    .D_type       (D_type),
    .ls_index     (ls_index),
    .ls_tag_in    (ls_tag_in),
    .ls_read      (ls_read),
    .ls_tag_write (ls_tag_write),
    .ls_mask      (ls_mask),
    .ls_line_in   (ls_line_in),
    .ls_tag_out   (ls_tag_out),
    .ls_valid     (ls_valid),
    .ls_line_out  (ls_line_out),
    .sm_mask      (sm_mask),
    .sm_line      (sm_line)
  );

  l1d_line_store line_store_inst (
    .clk       (clk),
    .rst       (rst),
    .index     (ls_index),
    .tag_in    (ls_tag_in),
    .read      (ls_read),
    .tag_write (ls_tag_write),
    .mask      (ls_mask),
    .line_in   (ls_line_in),
    .tag_out   (ls_tag_out),
    .valid     (ls_valid),
    .line_out  (ls_line_out)
  );

  // Core holds the store inputs stable for the whole transaction
  l1d_store_merge store_merge_inst (
    .offset   (core_addr[3:0]),
    .addr_low (core_addr[1:0]),
    .acc_type (core_type),
    .wdata    (core_in),
    .mask     (sm_mask),
    .line     (sm_line)
  );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps
// Word-wide memory responder with random wait cycles and byte-lane write merge
module tb_mem_model (
  input  logic               clk,
  input  logic               rst,
  input  logic               D_req,
  input  logic               D_write,
  input  l1d_pkg::addr_t     D_addr,
  input  l1d_pkg::word_t     D_in,
  input  l1d_pkg::acc_type_t D_type,
  output l1d_pkg::word_t     D_out,
  output logic               D_wait
);
  import l1d_pkg::*;

  localparam int MEM_WORDS = 1024;    // 4 KB window, addr[11:2]

  word_t      mem [MEM_WORDS];       // Filled by the testbench at time 0
  logic [1:0] wait_left;
  int         seed = 32'ha445bbb3;
  word_t      merged;

  assign D_wait = D_req && (wait_left != 2'd0);
  assign D_out  = mem[D_addr[11:2]];

  // Lane update from type and address low bits
  always_comb
  begin
    merged = mem[D_addr[11:2]];
    case (D_type)
      TYPE_BYTE, TYPE_BYTE_U:   merged[8*D_addr[1:0] +: 8] = D_in[7:0];
      TYPE_HWORD, TYPE_HWORD_U: merged[16*D_addr[1] +: 16] = D_in[15:0];
      TYPE_WORD:                merged = D_in;
      default:                  merged = mem[D_addr[11:2]];
    endcase
  end

  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wait_left <= 2'($unsigned($random(seed)) % 4);
    end
    else if (D_req && D_wait)
    begin
      wait_left <= wait_left - 2'd1;
    end
    else if (D_req)
    begin
      wait_left <= 2'($unsigned($random(seed)) % 4);  // Next beat
      if (D_write)
      begin
        mem[D_addr[11:2]] <= merged;
      end
    end
  end

endmodule

// ==== l1d_cache_properties.sv ====
`timescale 1ns/10ps
// Concurrent assertions on the memory and core ports of the L1 data cache
module l1d_cache_properties (
  input logic               clk,
  input logic               rst,
  input logic               D_req,
  input logic               D_wait,
  input logic               D_write,
  input l1d_pkg::addr_t     D_addr,
  input logic               core_wait
);
  import l1d_pkg::*;

  // ==================================================
  // Memory port
  // ==================================================
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    D_req && D_wait |=> D_req)
    else $error("D_req dropped before the beat completed");

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    D_req && D_wait |=> $stable(D_addr))
    else $error("D_addr changed while D_wait was high");

  a_write_has_req: assert property (@(posedge clk) disable iff (rst)
    !(D_write && !D_req))
    else $error("D_write high without D_req");

  // Core port right after reset
  a_wait_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !core_wait)
    else $error("core_wait high in the cycle after reset");

endmodule

bind l1d_cache l1d_cache_properties props_inst (
  .clk       (clk),
  .rst       (rst),
  .D_req     (D_req),
  .D_wait    (D_wait),
  .D_write   (D_write),
  .D_addr    (D_addr),
  .core_wait (core_wait)
);

// ==== tb_l1d_cache.sv ====
`timescale 1ns/10ps
// Testbench for the L1 data cache with a reference memory and a random access mix
module tb_l1d_cache;
  import l1d_pkg::*;

  localparam int DIRECTED_OPS   = 14;
  localparam int RAND_OPS       = 60;
  localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RAND_OPS) * 40 + 10;

  logic clk = 1'b0;
  logic rst;
  addr_t core_addr;
  logic core_req, core_write, core_wait, D_req, D_write, D_wait;
  word_t core_in, core_out, D_out, D_in;
  acc_type_t core_type, D_type;
  addr_t D_addr;

  word_t shadow [1024];
  word_t exp_word;
  string exp_name;
  addr_t beat_addr [$];
  logic  beat_write [$];
  int    seed = 32'ha445bbb3;
  int    cycle_count = 0;
  int    fail_count = 0;

  always #4 clk = ~clk;

  l1d_cache l1d_cache_inst (.*);

  tb_mem_model mem_model_inst (.*);

  // ==================================================
  // Reference model
  // ==================================================
  function automatic word_t fill_word(input int unsigned byte_addr);
    return (byte_addr * 32'h9e3779b1) ^ 32'h5a5a0000;
  endfunction

  // New memory word after a store of the given type at addr
  function automatic word_t ref_store(input word_t old, input addr_t addr,
                                      input acc_type_t typ, input word_t data);
    word_t w;
    w = old;
    if (typ == TYPE_BYTE || typ == TYPE_BYTE_U)
      w[8*addr[1:0] +: 8] = data[7:0];
    else if (typ == TYPE_HWORD || typ == TYPE_HWORD_U)
      w[16*addr[1] +: 16] = data[15:0];
    else if (typ == TYPE_WORD)
      w = data;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      fail_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Load result compared in the DONE cycle
  always @(posedge clk)
  begin
    if (!rst && core_req && !core_wait && !core_write)
      check_value(exp_name, exp_word, core_out);
  end

  always @(posedge clk)
  begin
    if (!rst && D_req && !D_wait)
    begin
      beat_addr.push_back(D_addr);
      beat_write.push_back(D_write);
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the cache did not finish its accesses in time");
      $display("TEST FAIL");
      $fatal(1, "Timeout");
    end
  end

  // One core access; returns memory beats and cycles with core_wait high
  task automatic access(input string name, input logic write, input addr_t addr,
                        input acc_type_t typ, input word_t data,
                        output int beats, output int waits);
    beat_addr.delete();
    beat_write.delete();
    @(posedge clk);
    // Expected values change only once the previous DONE edge has been checked
    if (write)
      shadow[addr[11:2]] = ref_store(shadow[addr[11:2]], addr, typ, data);
    else
      exp_word = shadow[addr[11:2]];
    exp_name = name;
    core_req   <= 1'b1;
    core_write <= write;
    core_addr  <= addr;
    core_type  <= typ;
    core_in    <= data;
    waits = 0;
    do
    begin
      @(posedge clk);
      if (core_wait)
        waits++;
    end while (core_wait);
    core_req   <= 1'b0;
    core_write <= 1'b0;
    beats = beat_addr.size();
    if (write)
    begin
      check_value({name, " beats"}, 1, beats);
      check_value({name, " beat addr"}, addr, beat_addr[0]);
      check_value({name, " beat write"}, 1, beat_write[0]);
      check_value({name, " memory"}, shadow[addr[11:2]],
                  mem_model_inst.mem[addr[11:2]]);
    end
  endtask

  task automatic check_refill(input string name, input addr_t addr, input int beats);
    check_value({name, " refill beats"}, 4, beats);
    for (int i = 0; i < 4; i++)
    begin
      check_value({name, " refill addr"}, {addr[31:4], 4'h0} + 4 * i, beat_addr[i]);
      check_value({name, " refill read"}, 0, beat_write[i]);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial
  begin
    int beats, waits;
    addr_t a;
    acc_type_t types [5];
    types = '{TYPE_BYTE, TYPE_HWORD, TYPE_WORD, TYPE_BYTE_U, TYPE_HWORD_U};
    for (int i = 0; i < 1024; i++)
    begin
      shadow[i] = fill_word(4 * i);
      mem_model_inst.mem[i] = fill_word(4 * i);
    end
    rst = 1'b1;
    core_req = 1'b0;
    core_write = 1'b0;
    core_addr = '0;
    core_type = TYPE_WORD;
    core_in = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    access("cold load", 0, 32'h124, TYPE_WORD, 0, beats, waits);
    check_refill("cold load", 32'h124, beats);
    access("hit load", 0, 32'h128, TYPE_WORD, 0, beats, waits);
    check_value("hit load beats", 0, beats);
    check_value("hit load latency", 2, waits);

    access("store byte", 1, 32'h125, TYPE_BYTE, 32'h5555_55ab, beats, waits);
    access("store hword", 1, 32'h12a, TYPE_HWORD, 32'h7777_c3d2, beats, waits);
    access("store byte_u", 1, 32'h12f, TYPE_BYTE_U, 32'h0000_0099, beats, waits);
    access("store hword_u", 1, 32'h12c, TYPE_HWORD_U, 32'h0000_1e2f, beats, waits);
    access("store word", 1, 32'h120, TYPE_WORD, 32'hdead_beef, beats, waits);
    access("load merged byte", 0, 32'h125, TYPE_WORD, 0, beats, waits);
    check_value("load merged byte beats", 0, beats);
    access("load merged hword", 0, 32'h12a, TYPE_WORD, 0, beats, waits);
    check_value("load merged hword beats", 0, beats);
    access("load merged lane3", 0, 32'h12c, TYPE_WORD, 0, beats, waits);
    check_value("load merged lane3 beats", 0, beats);

    access("store miss", 1, 32'h340, TYPE_WORD, 32'h1234_5678, beats, waits);
    access("load after miss", 0, 32'h340, TYPE_WORD, 0, beats, waits);
    check_refill("load after miss", 32'h340, beats);
    access("store miss byte", 1, 32'h751, TYPE_BYTE, 32'h0000_00e6, beats, waits);
    access("load after miss byte", 0, 32'h750, TYPE_WORD, 0, beats, waits);
    check_refill("load after miss byte", 32'h750, beats);

    // Three banks share indices 0..3 so lines evict each other
    for (int n = 0; n < RAND_OPS; n++)
    begin
      a = ($unsigned($random(seed)) % 3) << 10;
      a[5:4] = 2'($random(seed));
      a[3:0] = 4'($random(seed));
      if ($random(seed) & 1)
      begin
        access("random store", 1, a, types[$unsigned($random(seed)) % 5],
               $random(seed), beats, waits);
      end
      else
      begin
        access("random load", 0, a, TYPE_WORD, 0, beats, waits);
        if (beats != 0)
          check_refill("random load", a, beats);
      end
    end

    if (fail_count == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("TEST FAIL");
      $fatal(1, "Checks failed");
    end
  end

endmodule

// ==== all.f ====
l1d_pkg.sv
l1d_store_merge.sv
l1d_line_store.sv
l1d_controller.sv
l1d_cache.sv
tb_mem_model.sv
l1d_cache_properties.sv
tb_l1d_cache.sv

// ==== Makefile ====
# Verilator build for the L1 data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1d_cache
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
